// File: term_man.f
+incdir+design
design/term_key_pkg.sv
design/term_screen_pkg.sv
design/key_decode.sv
design/line_editor.sv
design/screen_buffer.sv
design/term_man.sv
sim/term_man_tb.sv

// File: Makefile
TOP = term_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f term_man.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f term_man.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: sim/term_man_tb.sv
`timescale 1ns/1ps
`include "term_consts.svh"

module term_tb;
        typedef struct packed {
                term_key_pkg::key_event_t key;
                logic                     burst;
                logic [2:0]               exp_mode;
        } entry_t;

        logic                        clk;
        logic                        rst_n;
        term_key_pkg::key_event_t    key;
        logic                        key_valid;
        logic                        key_ready;
        term_screen_pkg::row_t       rd_row;
        term_screen_pkg::col_t       rd_col;
        logic [7:0]                  rd_char;
        logic                        rd_cursor;
        term_screen_pkg::term_mode_t mode;
        logic                        busy;

        entry_t     table_q[$];
        logic [7:0] m_row5 [`TERM_COLS];
        logic [7:0] m_row6 [`TERM_MSG_LEN];
        int         m_cur;
        int         errors;
        int         tests;
        int         hs_cnt;
        int         stall_cnt;
        logic       timed_out;
        logic [8*`TERM_MSG_LEN-1:0] msg_txt = "Syntax error !!!!!";

        term_man DUT (
                .clk       (clk),
                .rst_n     (rst_n),
                .key       (key),
                .key_valid (key_valid),
                .key_ready (key_ready),
                .rd_row    (rd_row),
                .rd_col    (rd_col),
                .rd_char   (rd_char),
                .rd_cursor (rd_cursor),
                .mode      (mode),
                .busy      (busy)
        );

        always #4 clk = ~clk;

        // handshake and stall counters, sampled where the inputs are stable.
        always @(negedge clk) begin
                if (rst_n && key_valid && key_ready)
                        hs_cnt <= hs_cnt + 1;
                if (rst_n && key_valid && !key_ready)
                        stall_cnt <= stall_cnt + 1;
        end

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // table construction.
        function automatic logic [7:0] rand_letter();
                logic [7:0] c;
                c = "T";
                while (c == "T" || c == "G" || c == "C")
                        c = 8'h41 + 8'($urandom % 26);
                return c;
        endfunction

        function automatic logic is_enter(input term_key_pkg::key_event_t k);
                return k.ascii == `TERM_ENTER && !k.right && !k.left && !k.back && !k.esc;
        endfunction

        task automatic add(input logic [7:0] a, input logic r, input logic l,
                           input logic b, input logic e, input logic burst,
                           input logic [2:0] m);
                entry_t ent;
                ent.key.ascii = a;
                ent.key.right = r;
                ent.key.left  = l;
                ent.key.back  = b;
                ent.key.esc   = e;
                ent.burst     = burst;
                ent.exp_mode  = m;
                table_q.push_back(ent);
        endtask

        // expected screen contents, kept from the key rules.
        task automatic model_step(input term_key_pkg::key_event_t k, input logic [2:0] m);
                logic [7:0] lt;
                // outside command mode nothing reaches the screen.
                if (k.esc || m != 3'd0)
                        return;
                if (k.right) begin
                        if (m_cur < `TERM_LAST_COL)
                                m_cur++;
                end else if (k.left) begin
                        if (m_cur > `TERM_FIRST_COL)
                                m_cur--;
                end else if (k.back) begin
                        if (m_cur > `TERM_FIRST_COL) begin
                                m_cur--;
                                m_row5[m_cur] = `TERM_BLANK;
                        end
                end else if (k.ascii == `TERM_ENTER) begin
                        lt = m_row5[1];
                        for (int i = 0; i < `TERM_MSG_LEN; i++) begin
                                if (lt == "T" || lt == "G" || lt == "C")
                                        m_row6[i] = `TERM_BLANK;
                                else
                                        m_row6[i] = msg_txt[8*(`TERM_MSG_LEN-1-i) +: 8];
                        end
                        for (int c = 1; c < `TERM_COLS; c++) begin
                                if (c == 1 || !(lt == "T" || lt == "G" || lt == "C"))
                                        m_row5[c] = `TERM_BLANK;
                        end
                        m_cur = `TERM_FIRST_COL;
                end else begin
                        m_row5[m_cur] = k.ascii;
                        if (m_cur < `TERM_LAST_COL)
                                m_cur++;
                end
        endtask

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // bus tasks.
        task automatic send(input term_key_pkg::key_event_t k);
                int t;
                t = 0;
                @(posedge clk);
                key       <= k;
                key_valid <= 1'b1;
                @(negedge clk);
                while (!key_ready && t < 1000) begin
                        t++;
                        @(negedge clk);
                end
                if (!key_ready) begin
                        $display("timeout waiting for key_ready");
                        timed_out = 1'b1;
                        errors++;
                end
        endtask

        task automatic wait_idle(input logic exp_busy);
                int   t;
                logic seen;
                t = 0;
                seen = 1'b0;
                repeat (3) begin
                        @(negedge clk);
                        seen |= busy;
                end
                if (seen != exp_busy) begin
                        $display("[ERROR] busy got %h exp %h", seen, exp_busy);
                        errors++;
                end
                while (busy && t < 1000) begin
                        t++;
                        @(negedge clk);
                end
                if (busy) begin
                        $display("timeout waiting for busy to fall");
                        timed_out = 1'b1;
                        errors++;
                end
        endtask

        task automatic read_cell(input int row, input int col, output logic [7:0] ch,
                                 output logic cur);
                @(posedge clk);
                rd_row <= row[4:0];
                rd_col <= col[6:0];
                repeat (3) @(negedge clk);
                ch  = rd_char;
                cur = rd_cursor;
        endtask

        task automatic check_state(input logic [2:0] exp_mode, output int errs);
                logic [7:0] ch;
                logic       cu;
                errs = 0;
                for (int c = 0; c < `TERM_COLS; c++) begin
                        read_cell(`TERM_CMD_ROW, c, ch, cu);
                        if (ch != m_row5[c]) begin
                                $display("[ERROR] rd_char (5,%0d) got %h exp %h", c, ch, m_row5[c]);
                                errs++;
                        end
                        if (cu != (c == m_cur)) begin
                                $display("[ERROR] rd_cursor (5,%0d) got %h exp %h", c, cu, c == m_cur);
                                errs++;
                        end
                end
                for (int c = 0; c < `TERM_MSG_LEN; c++) begin
                        read_cell(`TERM_MSG_ROW, c, ch, cu);
                        if (ch != m_row6[c]) begin
                                $display("[ERROR] rd_char (6,%0d) got %h exp %h", c, ch, m_row6[c]);
                                errs++;
                        end
                end
                if (3'(mode) != exp_mode) begin
                        $display("[ERROR] mode got %h exp %h", 3'(mode), exp_mode);
                        errs++;
                end
        endtask

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // main sequence.
        initial begin
                int         errs;
                logic [7:0] cmd_letters [3];
                logic [2:0] cmd_modes [3];
                logic [2:0] prev_mode;
                void'($urandom(32'h08c0d648));
                clk = 1'b0;
                rst_n = 1'b0;
                key = '0;
                key_valid = 1'b0;
                rd_row = '0;
                rd_col = '0;
                errors = 0;
                tests = 0;
                hs_cnt = 0;
                stall_cnt = 0;
                timed_out = 1'b0;
                cmd_letters = '{"G", "T", "C"};
                cmd_modes = '{3'd1, 3'd3, 3'd4};
                for (int c = 0; c < `TERM_COLS; c++)
                        m_row5[c] = (c == 0) ? `TERM_PROMPT : `TERM_BLANK;
                for (int c = 0; c < `TERM_MSG_LEN; c++)
                        m_row6[c] = `TERM_BLANK;
                m_cur = `TERM_FIRST_COL;

                for (int i = 0; i < 85; i++)
                        add(rand_letter(), 0, 0, 0, 0, 0, 3'd0);
                add(8'h00, 1, 0, 0, 0, 0, 3'd0);
                add(8'h00, 0, 0, 1, 0, 0, 3'd0);
                add(8'h00, 0, 1, 0, 0, 0, 3'd0);
                add(8'h00, 1, 0, 0, 0, 0, 3'd0);
                for (int i = 0; i < 80; i++)
                        add(8'h00, 0, 1, 0, 0, 0, 3'd0);
                add(8'h00, 0, 0, 1, 0, 0, 3'd0);
                add(8'h00, 1, 0, 0, 0, 0, 3'd0);
                add(`TERM_ENTER, 0, 0, 0, 0, 0, 3'd0);
                for (int i = 0; i < 3; i++) begin
                        add(cmd_letters[i], 0, 0, 0, 0, 0, 3'd0);
                        add(`TERM_ENTER, 0, 0, 0, 0, 0, cmd_modes[i]);
                        add("X", 0, 0, 0, 0, 0, cmd_modes[i]);
                        add(8'h00, 0, 0, 0, 1, 0, 3'd0);
                end
                add("Z", 0, 0, 0, 0, 1, 3'd0);
                add("K", 0, 0, 0, 0, 1, 3'd0);
                add(`TERM_ENTER, 0, 0, 0, 0, 1, 3'd0);
                add("P", 0, 0, 0, 0, 1, 3'd0);
                add("Q", 0, 0, 0, 0, 0, 3'd0);

                repeat (10) @(posedge clk);
                rst_n <= 1'b1;
                wait_idle(1'b1);
                check_state(3'd0, errs);
                errors += errs;
                $display("test 0 startup: %0d errors", errs);

                for (int i = 0; i < table_q.size(); i++) begin
                        if (timed_out)
                                break;
                        prev_mode = (i == 0) ? 3'd0 : table_q[i-1].exp_mode;
                        model_step(table_q[i].key, prev_mode);
                        send(table_q[i].key);
                        if (!table_q[i].burst) begin
                                @(posedge clk);
                                key_valid <= 1'b0;
                                wait_idle(is_enter(table_q[i].key) && prev_mode == 3'd0);
                                check_state(table_q[i].exp_mode, errs);
                                errors += errs;
                                tests++;
                                $display("test %0d key %h: %0d errors", tests, table_q[i].key, errs);
                        end
                end
                // the burst must have been held off for the whole error sequence.
                if (stall_cnt < `TERM_ERR_WRITES) begin
                        $display("[ERROR] key_ready stall cycles got %h exp at least %h",
                                 stall_cnt, `TERM_ERR_WRITES);
                        errors++;
                end
                $display("tests %0d, handshakes %0d, errors %0d", tests + 1, hs_cnt, errors);
                if (errors == 0)
                        $display("Simulation finished: PASS");
                else
                        $display("Simulation finished: FAIL");
                $finish;
        end

endmodule

// File: design/term_man.sv
`timescale 1ns/1ps

module term_man (
        input  logic                        clk,
        input  logic                        rst_n,
        input  term_key_pkg::key_event_t    key,
        input  logic                        key_valid,
        output logic                        key_ready,
        input  term_screen_pkg::row_t       rd_row,
        input  term_screen_pkg::col_t       rd_col,
        output logic [7:0]                  rd_char,
        output logic                        rd_cursor,
        output term_screen_pkg::term_mode_t mode,
        output logic                        busy
);
        term_key_pkg::key_cmd_t      cmd;
        logic                        cmd_valid;
        logic                        cmd_ready;
        term_screen_pkg::screen_wr_t wr;
        term_screen_pkg::col_t       cursor;

        // key slice, editor, then the character store.
        key_decode u_decode (
                .clk       (clk),
                .rst_n     (rst_n),
                .key       (key),
                .key_valid (key_valid),
                .key_ready (key_ready),
                .cmd       (cmd),
                .cmd_valid (cmd_valid),
                .cmd_ready (cmd_ready)
        );

        line_editor u_editor (
                .clk       (clk),
                .rst_n     (rst_n),
                .cmd       (cmd),
                .cmd_valid (cmd_valid),
                .cmd_ready (cmd_ready),
                .wr        (wr),
                .cursor    (cursor),
                .mode      (mode),
                .busy      (busy)
        );

        screen_buffer u_screen (
                .clk       (clk),
                .rst_n     (rst_n),
                .wr        (wr),
                .cursor    (cursor),
                .rd_row    (rd_row),
                .rd_col    (rd_col),
                .rd_char   (rd_char),
                .rd_cursor (rd_cursor)
        );

endmodule

// File: design/screen_buffer.sv
`timescale 1ns/1ps
`include "term_consts.svh"

module screen_buffer (
        input  logic                        clk,
        input  logic                        rst_n,
        input  term_screen_pkg::screen_wr_t wr,
        input  term_screen_pkg::col_t       cursor,
        input  term_screen_pkg::row_t       rd_row,
        input  term_screen_pkg::col_t       rd_col,
        output logic [7:0]                  rd_char,
        output logic                        rd_cursor
);
        logic [7:0]                  mem [`TERM_CELLS];
        term_screen_pkg::cell_addr_t rd_addr;
        logic                        on_cursor;

        assign rd_addr = term_screen_pkg::cell_index(rd_row, rd_col);

        // cursor only lives on the command row.
        assign on_cursor = (rd_row == `TERM_CMD_ROW) && (rd_col == cursor);

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // character store, one write and one read port.
        always_ff @(posedge clk) begin
                if (wr.en)
                        mem[wr.addr] <= wr.data;
        end

        always_ff @(posedge clk) begin
                rd_char <= mem[rd_addr];
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n)
                        rd_cursor <= 1'b0;
                else
                        rd_cursor <= on_cursor;
        end

        rd_col_range: assert property (@(posedge clk) disable iff (!rst_n)
                rd_col < `TERM_COLS);

endmodule

// File: design/line_editor.sv
`timescale 1ns/1ps
`include "term_consts.svh"

module line_editor (
        input  logic                        clk,
        input  logic                        rst_n,
        input  term_key_pkg::key_cmd_t      cmd,
        input  logic                        cmd_valid,
        output logic                        cmd_ready,
        output term_screen_pkg::screen_wr_t wr,
        output term_screen_pkg::col_t       cursor,
        output term_screen_pkg::term_mode_t mode,
        output logic                        busy
);
        typedef enum logic [1:0] {
                SEQ_IDLE,
                SEQ_INIT,
                SEQ_OK,
                SEQ_ERR
        } seq_state_t;

        localparam term_screen_pkg::row_t cmd_row   = `TERM_CMD_ROW;
        localparam term_screen_pkg::row_t msg_row   = `TERM_MSG_ROW;
        localparam term_screen_pkg::col_t first_col = `TERM_FIRST_COL;
        localparam term_screen_pkg::col_t last_col  = `TERM_LAST_COL;
        localparam logic [7:0] msg_len   = `TERM_MSG_LEN;
        localparam logic [7:0] init_last = `TERM_INIT_WRITES - 1;
        localparam logic [7:0] ok_last   = `TERM_OK_WRITES - 1;
        localparam logic [7:0] err_last  = `TERM_ERR_WRITES - 1;
        localparam logic [8*`TERM_MSG_LEN-1:0] err_msg = "Syntax error !!!!!";

        seq_state_t                  state;
        logic [7:0]                  seq_cnt;
        logic [7:0]                  letter;
        term_screen_pkg::screen_wr_t seq_wr;
        logic                        seq_last;

        assign cmd_ready = (state == SEQ_IDLE);
        assign busy      = (state != SEQ_IDLE);

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // bulk write sequences, one cell per cycle.
        always_comb begin
                seq_wr.en   = 1'b1;
                seq_wr.addr = term_screen_pkg::cell_index(msg_row, '0) + seq_cnt;
                seq_wr.data = `TERM_BLANK;
                seq_last    = 1'b0;
                case (state)
                SEQ_INIT: begin
                        // rows 5 and 6 back to back, prompt first.
                        seq_wr.addr = term_screen_pkg::cell_index(cmd_row, '0) + seq_cnt;
                        if (seq_cnt == '0)
                                seq_wr.data = `TERM_PROMPT;
                        seq_last = (seq_cnt == init_last);
                end
                SEQ_OK: begin
                        if (seq_cnt >= msg_len)
                                seq_wr.addr = term_screen_pkg::cell_index(cmd_row, first_col);
                        seq_last = (seq_cnt == ok_last);
                end
                SEQ_ERR: begin
                        if (seq_cnt < msg_len) begin
                                seq_wr.data = err_msg[8*(msg_len-8'd1-seq_cnt) +: 8];
                        end else begin
                                seq_wr.addr = term_screen_pkg::cell_index(cmd_row, first_col)
                                        + seq_cnt - msg_len;
                        end
                        seq_last = (seq_cnt == err_last);
                end
                default: begin
                        seq_wr.en = 1'b0;
                end
                endcase
        end

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // command execution.
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        state   <= SEQ_INIT;
                        seq_cnt <= '0;
                        letter  <= `TERM_BLANK;
                        cursor  <= first_col;
                        mode    <= term_screen_pkg::MODE_CMD;
                        wr      <= '0;
                end else begin
                        wr.en <= 1'b0;
                        if (state != SEQ_IDLE) begin
                                wr      <= seq_wr;
                                seq_cnt <= seq_cnt + 8'd1;
                                if (seq_last) begin
                                        state   <= SEQ_IDLE;
                                        seq_cnt <= '0;
                                end
                        end else if (cmd_valid) begin
                                if (cmd.op == term_key_pkg::OP_ESC) begin
                                        mode <= term_screen_pkg::MODE_CMD;
                                end else if (mode == term_screen_pkg::MODE_CMD) begin
                                        case (cmd.op)
                                        term_key_pkg::OP_CHAR: begin
                                                wr <= '{en: 1'b1,
                                                        addr: term_screen_pkg::cell_index(cmd_row, cursor),
                                                        data: cmd.ascii};
                                                if (cursor == first_col)
                                                        letter <= cmd.ascii;
                                                if (cursor != last_col)
                                                        cursor <= cursor + 7'd1;
                                        end
                                        term_key_pkg::OP_RIGHT: begin
                                                if (cursor != last_col)
                                                        cursor <= cursor + 7'd1;
                                        end
                                        term_key_pkg::OP_LEFT: begin
                                                // prompt column stays out of reach.
                                                if (cursor != first_col)
                                                        cursor <= cursor - 7'd1;
                                        end
                                        term_key_pkg::OP_BACK: begin
                                                if (cursor != first_col) begin
                                                        cursor <= cursor - 7'd1;
                                                        wr <= '{en: 1'b1,
                                                                addr: term_screen_pkg::cell_index(
                                                                        cmd_row, cursor - 7'd1),
                                                                data: `TERM_BLANK};
                                                        if (cursor == first_col + 7'd1)
                                                                letter <= `TERM_BLANK;
                                                end
                                        end
                                        term_key_pkg::OP_ENTER: begin
                                                cursor <= first_col;
                                                letter <= `TERM_BLANK;
                                                state  <= SEQ_OK;
                                                case (letter)
                                                "T": mode <= term_screen_pkg::MODE_TEXT;
                                                "G": mode <= term_screen_pkg::MODE_GRAPHICS;
                                                "C": mode <= term_screen_pkg::MODE_CALC;
                                                default: state <= SEQ_ERR;
                                                endcase
                                        end
                                        default: begin
                                        end
                                        endcase
                                end
                        end
                end
        end

        cursor_range: assert property (@(posedge clk) disable iff (!rst_n)
                cursor >= first_col && cursor <= last_col);

        wr_range: assert property (@(posedge clk) disable iff (!rst_n)
                wr.en |-> wr.addr < `TERM_CELLS);

endmodule

// File: design/key_decode.sv
`timescale 1ns/1ps
`include "term_consts.svh"

module key_decode (
        input  logic                     clk,
        input  logic                     rst_n,
        input  term_key_pkg::key_event_t key,
        input  logic                     key_valid,
        output logic                     key_ready,
        output term_key_pkg::key_cmd_t   cmd,
        output logic                     cmd_valid,
        input  logic                     cmd_ready
);
        term_key_pkg::key_op_t op;
        logic                  live;

        // esc wins, then the movement flags, then enter.
        always_comb begin
                if (key.esc)
                        op = term_key_pkg::OP_ESC;
                else if (key.right)
                        op = term_key_pkg::OP_RIGHT;
                else if (key.left)
                        op = term_key_pkg::OP_LEFT;
                else if (key.back)
                        op = term_key_pkg::OP_BACK;
                else if (key.ascii == `TERM_ENTER)
                        op = term_key_pkg::OP_ENTER;
                else
                        op = term_key_pkg::OP_CHAR;
        end

        assign key_ready = live && (!cmd_valid || cmd_ready);

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        live      <= 1'b0;
                        cmd_valid <= 1'b0;
                end else begin
                        live <= 1'b1;
                        if (key_valid && key_ready)
                                cmd_valid <= 1'b1;
                        else if (cmd_ready)
                                cmd_valid <= 1'b0;
                end
        end

        always_ff @(posedge clk) begin
                if (key_valid && key_ready)
                        cmd <= '{op: op, ascii: key.ascii};
        end

        cmd_hold: assert property (@(posedge clk) disable iff (!rst_n)
                cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd));

endmodule

// File: design/term_screen_pkg.sv
`include "term_consts.svh"

package term_screen_pkg;

        // linear index into the 80x30 cell array.
        typedef logic [11:0] cell_addr_t;
        typedef logic [6:0]  col_t;
        typedef logic [4:0]  row_t;

        // single cell write, no handshake.
        typedef struct packed {
                logic       en;
                cell_addr_t addr;
                logic [7:0] data;
        } screen_wr_t;

        // terminal modes, codes kept from the old design.
        typedef enum logic [2:0] {
                MODE_CMD      = 3'd0,
                MODE_GRAPHICS = 3'd1,
                MODE_TEXT     = 3'd3,
                MODE_CALC     = 3'd4
        } term_mode_t;

        // row-major cell index.
        function automatic cell_addr_t cell_index(
                input row_t row,
                input col_t col
        );
                return cell_addr_t'(row * `TERM_COLS + col);
        endfunction

endpackage

// File: design/term_key_pkg.sv
package term_key_pkg;

        // one key event from the keyboard side.
        typedef struct packed {
                logic [7:0] ascii;
                logic       right;
                logic       left;
                logic       back;
                logic       esc;
        } key_event_t;

        // decoded key class, one per event.
        typedef enum logic [2:0] {
                OP_CHAR  = 3'd0,
                OP_ENTER = 3'd1,
                OP_RIGHT = 3'd2,
                OP_LEFT  = 3'd3,
                OP_BACK  = 3'd4,
                OP_ESC   = 3'd5
        } key_op_t;

        // command handed to the editor.
        typedef struct packed {
                key_op_t    op;
                logic [7:0] ascii;
        } key_cmd_t;

endpackage

// File: design/term_consts.svh
`ifndef TERM_CONSTS_SVH
`define TERM_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// screen geometry.
`define TERM_COLS        80
`define TERM_ROWS        30
`define TERM_CELLS       2400
`define TERM_CMD_ROW     5
`define TERM_MSG_ROW     6
`define TERM_FIRST_COL   1
`define TERM_LAST_COL    79
`define TERM_MSG_LEN     18

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// key and character codes.
`define TERM_PROMPT      8'h2D
`define TERM_ENTER       8'h0D
`define TERM_BLANK       8'h00

// write counts of the editor sequences.
`define TERM_INIT_WRITES 160
`define TERM_OK_WRITES   19
`define TERM_ERR_WRITES  97

`endif
